/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_rv_slice
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/branch_unit.sv */
module branch_unit import rv_pkg::*; (
    input  xlen_t      rs1_i,
    input  xlen_t      rs2_i,
    input  xlen_t      pc_i,
    input  xlen_t      imm_i,
    input  logic [2:0] fun3_i,
    input  logic       is_branch_i,
    input  logic       is_jal_i,
    input  logic       is_jalr_i,
    output xlen_t      pc_next_o,
    output logic       is_jump_o
);

    logic  cond;
    logic  taken;
    xlen_t jalr_target;

    always_comb begin
        case (fun3_i)
            3'b000:  cond = (rs1_i == rs2_i);
            3'b001:  cond = (rs1_i != rs2_i);
            3'b100:  cond = ($signed(rs1_i) < $signed(rs2_i));
            3'b101:  cond = ($signed(rs1_i) >= $signed(rs2_i));
            3'b110:  cond = (rs1_i < rs2_i);
            3'b111:  cond = (rs1_i >= rs2_i);
            // 010 and 011 are not branches
            default: cond = 1'b0;
        endcase
    end

    assign taken       = is_branch_i && cond;
    assign jalr_target = (rs1_i + imm_i) & ~xlen_t'(1);

    assign pc_next_o = is_jalr_i             ? jalr_target :
                       (taken || is_jal_i)   ? pc_i + imm_i :
                                               pc_i + xlen_t'(4);
    assign is_jump_o = taken || is_jal_i || is_jalr_i;

endmodule

/* design/decoder.sv */
module decoder import rv_pkg::*; (
    input  instr_t    instr_i,
    output imm_kind_e imm_kind_o,
    output src1_sel_e src1_sel_o,
    output src2_sel_e src2_sel_o,
    output alu_op_e   alu_op_o,
    output logic      is_branch_o,
    output logic      is_jal_o,
    output logic      is_jalr_o
);

    logic [4:0] opcode;
    logic [2:0] fun3;
    logic [6:0] fun7;
    logic       is_word;

    assign opcode  = instr_i[6:2];
    assign fun3    = instr_i[14:12];
    assign fun7    = instr_i[31:25];
    // OP_*_32 differ from OP_* only in this bit
    assign is_word = opcode[1];

    always_comb begin
        imm_kind_o  = IMM_NONE;
        src1_sel_o  = SRC1_RS1;
        src2_sel_o  = SRC2_RS2;
        alu_op_o    = ALU_ADD;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;

        case (opcode)
            OP_REG, OP_REG_32, OP_IMM, OP_IMM_32: begin
                // immediate forms share the fun3 table
                if (opcode == OP_IMM || opcode == OP_IMM_32) begin
                    imm_kind_o = IMM_I;
                    src2_sel_o = SRC2_IMM;
                end
                case (fun3)
                    3'b000: begin
                        // no SUBI, so fun7 only counts for R-type
                        if (fun7[5] && opcode[3]) begin
                            alu_op_o = is_word ? ALU_SUBW : ALU_SUB;
                        end else begin
                            alu_op_o = is_word ? ALU_ADDW : ALU_ADD;
                        end
                    end
                    3'b001: alu_op_o = is_word ? ALU_SLLW : ALU_SLL;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b101: begin
                        if (fun7[5]) begin
                            alu_op_o = is_word ? ALU_SRAW : ALU_SRA;
                        end else begin
                            alu_op_o = is_word ? ALU_SRLW : ALU_SRL;
                        end
                    end
                    3'b110: alu_op_o = ALU_OR;
                    default: alu_op_o = ALU_AND;
                endcase
            end
            LOAD: begin
                // address only
                imm_kind_o = IMM_I;
                src2_sel_o = SRC2_IMM;
            end
            STORE: begin
                imm_kind_o = IMM_S;
                src2_sel_o = SRC2_IMM;
            end
            BRANCH: begin
                imm_kind_o  = IMM_B;
                is_branch_o = 1'b1;
            end
            JAL: begin
                // link value pc + 4
                imm_kind_o = IMM_J;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_FOUR;
                is_jal_o   = 1'b1;
            end
            JALR: begin
                imm_kind_o = IMM_I;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_FOUR;
                is_jalr_o  = 1'b1;
            end
            LUI: begin
                imm_kind_o = IMM_U;
                src2_sel_o = SRC2_IMM;
                alu_op_o   = ALU_SRC2;
            end
            AUIPC: begin
                imm_kind_o = IMM_U;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_IMM;
            end
            default: begin
                // unknown opcode, defaults stand
            end
        endcase
    end

endmodule

/* design/exec_unit.sv */
module exec_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    op_if.sink    op,
    output xlen_t result_o,
    output xlen_t rs2_o,
    output xlen_t pc_next_o,
    output logic  is_jump_o,
    output logic  valid_o
);

    xlen_t       alu_res;
    logic [31:0] a_w;
    logic [31:0] b_w;
    logic        lt_s;
    logic        lt_u;

    // word results are sign-extended from bit 31
    function automatic xlen_t sext32(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

    assign a_w  = op.src1[31:0];
    assign b_w  = op.src2[31:0];
    assign lt_s = $signed(op.src1) < $signed(op.src2);
    assign lt_u = op.src1 < op.src2;

    always_comb begin
        case (op.alu_op)
            ALU_ADD:  alu_res = op.src1 + op.src2;
            ALU_SUB:  alu_res = op.src1 - op.src2;
            ALU_SLL:  alu_res = op.src1 << op.src2[5:0];
            ALU_SRL:  alu_res = op.src1 >> op.src2[5:0];
            ALU_SRA:  alu_res = xlen_t'($signed(op.src1) >>> op.src2[5:0]);
            ALU_ADDW: alu_res = sext32(a_w + b_w);
            ALU_SUBW: alu_res = sext32(a_w - b_w);
            // word shifts use only 5 bits of the amount
            ALU_SLLW: alu_res = sext32(a_w << b_w[4:0]);
            ALU_SRLW: alu_res = sext32(a_w >> b_w[4:0]);
            ALU_SRAW: alu_res = sext32($signed(a_w) >>> b_w[4:0]);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_res = op.src1 ^ op.src2;
            ALU_OR:   alu_res = op.src1 | op.src2;
            ALU_AND:  alu_res = op.src1 & op.src2;
            default:  alu_res = op.src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o  <= '0;
            rs2_o     <= '0;
            pc_next_o <= '0;
            is_jump_o <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            valid_o   <= op.valid;
            // jump flag only means something with valid
            is_jump_o <= op.valid && op.is_jump;
            if (op.valid) begin
                result_o  <= alu_res;
                rs2_o     <= op.rs2_data;
                pc_next_o <= op.pc_next;
            end
        end
    end

endmodule

/* design/id_stage.sv */
module id_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      valid_i,
    input  xlen_t     pc_i,
    input  instr_t    instr_i,
    input  logic      wb_en_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i,
    op_if.source      op
);

    xlen_t     rs1;
    xlen_t     rs2;
    xlen_t     imm;
    imm_kind_e imm_kind;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    alu_op_e   alu_op;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;

    regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rs1_data_o (rs1),
        .rs2_data_o (rs2),
        .wr_en_i    (wb_en_i),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i)
    );

    decoder u_decoder (
        .instr_i     (instr_i),
        .imm_kind_o  (imm_kind),
        .src1_sel_o  (src1_sel),
        .src2_sel_o  (src2_sel),
        .alu_op_o    (alu_op),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr)
    );

    imm_ext u_imm_ext (
        .instr_i (instr_i),
        .kind_i  (imm_kind),
        .imm_o   (imm)
    );

    branch_unit u_branch_unit (
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .pc_i        (pc_i),
        .imm_i       (imm),
        .fun3_i      (instr_i[14:12]),
        .is_branch_i (is_branch),
        .is_jal_i    (is_jal),
        .is_jalr_i   (is_jalr),
        .pc_next_o   (op.pc_next),
        .is_jump_o   (op.is_jump)
    );

    // operand muxes
    assign op.src1 = (src1_sel == SRC1_PC) ? pc_i : rs1;

    always_comb begin
        case (src2_sel)
            SRC2_IMM:  op.src2 = imm;
            SRC2_FOUR: op.src2 = xlen_t'(4);
            default:   op.src2 = rs2;
        endcase
    end

    assign op.valid    = valid_i;
    assign op.alu_op   = alu_op;
    assign op.rs2_data = rs2;

endmodule

/* design/imm_ext.sv */
module imm_ext import rv_pkg::*; (
    input  instr_t    instr_i,
    input  imm_kind_e kind_i,
    output xlen_t     imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (kind_i)
            IMM_I: imm_o = {{52{sign}}, instr_i[31:20]};
            IMM_U: imm_o = {{32{sign}}, instr_i[31:12], 12'h000};
            IMM_S: imm_o = {{52{sign}}, instr_i[31:25], instr_i[11:7]};
            // J and B scatter the offset bits, lsb always zero
            IMM_J: begin
                imm_o = {{44{sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            IMM_B: begin
                imm_o = {{52{sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

/* design/op_if.sv */
interface op_if import rv_pkg::*; ();

    logic    valid;
    xlen_t   src1;
    xlen_t   src2;
    alu_op_e alu_op;
    // store data
    xlen_t   rs2_data;
    xlen_t   pc_next;
    logic    is_jump;

    modport source (
        output valid, src1, src2, alu_op, rs2_data, pc_next, is_jump
    );

    modport sink (
        input valid, src1, src2, alu_op, rs2_data, pc_next, is_jump
    );

endinterface

/* design/regfile.sv */
module regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  xlen_t     wr_data_i
);

    xlen_t regs [NREGS];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // reads see the value before a same-cycle write
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN    = 64;
    localparam int NREGS   = 32;
    localparam int REG_AW  = $clog2(NREGS);
    localparam int INSTR_W = 32;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;

    // major opcodes, instruction bits 6..2
    localparam logic [4:0] OP_REG    = 5'b01100;
    localparam logic [4:0] OP_REG_32 = 5'b01110;
    localparam logic [4:0] OP_IMM    = 5'b00100;
    localparam logic [4:0] OP_IMM_32 = 5'b00110;
    localparam logic [4:0] LOAD      = 5'b00000;
    localparam logic [4:0] STORE     = 5'b01000;
    localparam logic [4:0] BRANCH    = 5'b11000;
    localparam logic [4:0] JAL       = 5'b11011;
    localparam logic [4:0] JALR      = 5'b11001;
    localparam logic [4:0] LUI       = 5'b01101;
    localparam logic [4:0] AUIPC     = 5'b00101;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // 32-bit word forms
        ALU_ADDW,
        ALU_SUBW,
        ALU_SLLW,
        ALU_SRLW,
        ALU_SRAW,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        // pass operand 2
        ALU_SRC2
    } alu_op_e;

    // one-hot immediate kind
    typedef enum logic [4:0] {
        IMM_NONE = 5'b00000,
        IMM_I    = 5'b00001,
        IMM_U    = 5'b00010,
        IMM_S    = 5'b00100,
        IMM_J    = 5'b01000,
        IMM_B    = 5'b10000
    } imm_kind_e;

    typedef enum logic {
        SRC1_RS1,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RS2,
        SRC2_IMM,
        SRC2_FOUR
    } src2_sel_e;

endpackage

/* design/rv_slice_top.sv */
module rv_slice_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      valid_i,
    input  xlen_t     pc_i,
    input  instr_t    instr_i,
    input  logic      wb_en_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i,
    output xlen_t     result_o,
    output xlen_t     rs2_o,
    output xlen_t     pc_next_o,
    output logic      is_jump_o,
    output logic      valid_o
);

    // decoded operation, decode to execute
    op_if op ();

    id_stage u_id_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .pc_i      (pc_i),
        .instr_i   (instr_i),
        .wb_en_i   (wb_en_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i),
        .op        (op.source)
    );

    exec_unit u_exec_unit (
        .clk       (clk),
        .reset_i   (reset_i),
        .op        (op.sink),
        .result_o  (result_o),
        .rs2_o     (rs2_o),
        .pc_next_o (pc_next_o),
        .is_jump_o (is_jump_o),
        .valid_o   (valid_o)
    );

endmodule

/* flist.f */
design/rv_pkg.sv
design/op_if.sv
design/regfile.sv
design/decoder.sv
design/imm_ext.sv
design/branch_unit.sv
design/id_stage.sv
design/exec_unit.sv
design/rv_slice_top.sv
tests/tb_rv_slice.sv

/* tests/tb_rv_slice.sv */
module tb_rv_slice import rv_pkg::*; ();

    localparam xlen_t BASE_PC  = 64'h1000;
    localparam int    WAIT_MAX = 10;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      valid_i;
    xlen_t     pc_i;
    instr_t    instr_i;
    logic      wb_en_i;
    reg_addr_t wb_addr_i;
    xlen_t     wb_data_i;
    xlen_t     result_o;
    xlen_t     rs2_o;
    xlen_t     pc_next_o;
    logic      is_jump_o;
    logic      valid_o;

    // one table entry per index across these queues
    string  name_q[$];
    xlen_t  pc_q[$];
    instr_t instr_q[$];
    xlen_t  res_q[$];
    logic   chk_res_q[$];
    xlen_t  nxt_q[$];
    logic   jmp_q[$];
    logic   chk_rs2_q[$];
    xlen_t  rs2_q[$];

    rv_slice_top DUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .pc_i      (pc_i),
        .instr_i   (instr_i),
        .wb_en_i   (wb_en_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i),
        .result_o  (result_o),
        .rs2_o     (rs2_o),
        .pc_next_o (pc_next_o),
        .is_jump_o (is_jump_o),
        .valid_o   (valid_o)
    );

    always #2 clk = ~clk;

    // instruction encoders, rd is always x7 as a scratch target
    function automatic instr_t r_enc(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                     input logic [4:0] op5);
        return {f7, rs2, rs1, f3, 5'd7, op5, 2'b11};
    endfunction

    function automatic instr_t i_enc(input logic [2:0] f3, input reg_addr_t rs1,
                                     input logic [11:0] imm, input logic [4:0] op5);
        return {imm, rs1, f3, 5'd7, op5, 2'b11};
    endfunction

    function automatic instr_t s_enc(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE, 2'b11};
    endfunction

    function automatic instr_t b_enc(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH, 2'b11};
    endfunction

    function automatic instr_t u_enc(input logic [19:0] imm, input logic [4:0] op5);
        return {imm, 5'd7, op5, 2'b11};
    endfunction

    function automatic instr_t j_enc(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd7, JAL, 2'b11};
    endfunction

    // x0 gets a nonzero value that must be dropped
    function automatic xlen_t preload_value(input int k);
        case (k)
            0:       return 64'h5a5a_5a5a_5a5a_5a5a;
            1:       return 64'h10;
            2:       return 64'hffff_ffff_ffff_fff0;
            3:       return 64'h7fff_ffff;
            4:       return 64'h4;
            5:       return 64'h8000_0000_0000_0000;
            default: return 64'h10;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string name, input string what,
                               input xlen_t exp_v, input xlen_t act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("[ERROR] %s %s: expected 0x%h, actual 0x%h",
                               name, what, exp_v, act_v));
        end
    endtask

    task automatic push_case(input string name, input xlen_t pc, input instr_t instr,
                             input xlen_t res, input logic chk_res, input xlen_t nxt,
                             input logic jmp);
        name_q.push_back(name);
        pc_q.push_back(pc);
        instr_q.push_back(instr);
        res_q.push_back(res);
        chk_res_q.push_back(chk_res);
        nxt_q.push_back(nxt);
        jmp_q.push_back(jmp);
        chk_rs2_q.push_back(1'b0);
        rs2_q.push_back('0);
    endtask

    task automatic add_alu(input string name, input instr_t instr, input xlen_t res);
        push_case(name, BASE_PC, instr, res, 1'b1, BASE_PC + 64'd4, 1'b0);
    endtask

    // branch results are not defined, only the next pc and the flag
    task automatic add_branch(input string name, input instr_t instr,
                              input xlen_t nxt, input logic jmp);
        push_case(name, BASE_PC, instr, '0, 1'b0, nxt, jmp);
    endtask

    task automatic expect_rs2(input xlen_t v);
        int last;
        last = rs2_q.size() - 1;
        chk_rs2_q[last] = 1'b1;
        rs2_q[last] = v;
    endtask

    task automatic build_table();
        add_alu("add",  r_enc(7'h00, 3'd0, 5'd1, 5'd3, OP_REG), 64'h8000_000f);
        add_alu("sub",  r_enc(7'h20, 3'd0, 5'd1, 5'd2, OP_REG), 64'h20);
        add_alu("sll",  r_enc(7'h00, 3'd1, 5'd1, 5'd4, OP_REG), 64'h100);
        add_alu("srl",  r_enc(7'h00, 3'd5, 5'd2, 5'd4, OP_REG), 64'h0fff_ffff_ffff_ffff);
        add_alu("sra",  r_enc(7'h20, 3'd5, 5'd2, 5'd4, OP_REG), 64'hffff_ffff_ffff_ffff);
        add_alu("slt",  r_enc(7'h00, 3'd2, 5'd2, 5'd1, OP_REG), 64'h1);
        add_alu("sltu", r_enc(7'h00, 3'd3, 5'd2, 5'd1, OP_REG), 64'h0);
        add_alu("xor",  r_enc(7'h00, 3'd4, 5'd1, 5'd3, OP_REG), 64'h7fff_ffef);
        add_alu("or",   r_enc(7'h00, 3'd6, 5'd1, 5'd4, OP_REG), 64'h14);
        add_alu("and",  r_enc(7'h00, 3'd7, 5'd2, 5'd3, OP_REG), 64'h7fff_fff0);
        // word forms, results sign-extended from bit 31
        add_alu("addw", r_enc(7'h00, 3'd0, 5'd3, 5'd1, OP_REG_32), 64'hffff_ffff_8000_000f);
        add_alu("subw", r_enc(7'h20, 3'd0, 5'd1, 5'd3, OP_REG_32), 64'hffff_ffff_8000_0011);
        add_alu("sllw", r_enc(7'h00, 3'd1, 5'd3, 5'd4, OP_REG_32), 64'hffff_ffff_ffff_fff0);
        add_alu("srlw", r_enc(7'h00, 3'd5, 5'd2, 5'd4, OP_REG_32), 64'h0fff_ffff);
        add_alu("sraw", r_enc(7'h20, 3'd5, 5'd2, 5'd4, OP_REG_32), 64'hffff_ffff_ffff_ffff);
        // immediates, mostly negative
        add_alu("addi",  i_enc(3'd0, 5'd1, 12'hfec, OP_IMM), 64'hffff_ffff_ffff_fffc);
        add_alu("slti",  i_enc(3'd2, 5'd1, 12'hfff, OP_IMM), 64'h0);
        add_alu("sltiu", i_enc(3'd3, 5'd1, 12'hfff, OP_IMM), 64'h1);
        add_alu("xori",  i_enc(3'd4, 5'd1, 12'hfff, OP_IMM), 64'hffff_ffff_ffff_ffef);
        add_alu("ori",   i_enc(3'd6, 5'd4, 12'hff0, OP_IMM), 64'hffff_ffff_ffff_fff4);
        add_alu("andi",  i_enc(3'd7, 5'd3, 12'hf00, OP_IMM), 64'h7fff_ff00);
        add_alu("slli",  i_enc(3'd1, 5'd1, 12'h03b, OP_IMM), 64'h8000_0000_0000_0000);
        add_alu("srli",  i_enc(3'd5, 5'd5, 12'h03f, OP_IMM), 64'h1);
        add_alu("srai",  i_enc(3'd5, 5'd5, 12'h43f, OP_IMM), 64'hffff_ffff_ffff_ffff);
        add_alu("addiw", i_enc(3'd0, 5'd3, 12'h001, OP_IMM_32), 64'hffff_ffff_8000_0000);
        add_alu("srliw", i_enc(3'd5, 5'd2, 12'h004, OP_IMM_32), 64'h0fff_ffff);
        add_alu("sraiw", i_enc(3'd5, 5'd2, 12'h404, OP_IMM_32), 64'hffff_ffff_ffff_ffff);
        add_alu("lui",     u_enc(20'h80000, LUI), 64'hffff_ffff_8000_0000);
        add_alu("lui_pos", u_enc(20'h12345, LUI), 64'h1234_5000);
        add_alu("auipc",   u_enc(20'h12345, AUIPC), 64'h1234_6000);
        push_case("auipc_neg", 64'h3000, u_enc(20'hfffff, AUIPC), 64'h2000, 1'b1,
                  64'h3004, 1'b0);
        // jumps link to pc + 4
        push_case("jal_fwd", 64'h2000, j_enc(21'h000800), 64'h2004, 1'b1, 64'h2800, 1'b1);
        push_case("jal_back", BASE_PC, j_enc(21'h1ffff0), 64'h1004, 1'b1, 64'hff0, 1'b1);
        push_case("jalr", BASE_PC, i_enc(3'd0, 5'd1, 12'h005, JALR), 64'h1004, 1'b1,
                  64'h14, 1'b1);
        push_case("jalr_neg", BASE_PC, i_enc(3'd0, 5'd1, 12'hffd, JALR), 64'h1004, 1'b1,
                  64'hc, 1'b1);
        add_branch("beq_t",  b_enc(3'd0, 5'd1, 5'd6, 13'h0040), 64'h1040, 1'b1);
        add_branch("beq_n",  b_enc(3'd0, 5'd1, 5'd2, 13'h0040), 64'h1004, 1'b0);
        add_branch("bne_t",  b_enc(3'd1, 5'd1, 5'd2, 13'h1ff8), 64'hff8, 1'b1);
        add_branch("bne_n",  b_enc(3'd1, 5'd1, 5'd6, 13'h1ff8), 64'h1004, 1'b0);
        add_branch("blt_t",  b_enc(3'd4, 5'd2, 5'd1, 13'h0040), 64'h1040, 1'b1);
        add_branch("blt_n",  b_enc(3'd4, 5'd1, 5'd2, 13'h0040), 64'h1004, 1'b0);
        add_branch("bge_t",  b_enc(3'd5, 5'd1, 5'd2, 13'h0040), 64'h1040, 1'b1);
        add_branch("bge_eq", b_enc(3'd5, 5'd1, 5'd6, 13'h0040), 64'h1040, 1'b1);
        add_branch("bge_n",  b_enc(3'd5, 5'd2, 5'd1, 13'h0040), 64'h1004, 1'b0);
        add_branch("bltu_t", b_enc(3'd6, 5'd1, 5'd2, 13'h0040), 64'h1040, 1'b1);
        add_branch("bltu_n", b_enc(3'd6, 5'd2, 5'd1, 13'h0040), 64'h1004, 1'b0);
        add_branch("bgeu_t", b_enc(3'd7, 5'd2, 5'd1, 13'h0040), 64'h1040, 1'b1);
        add_branch("bgeu_n", b_enc(3'd7, 5'd1, 5'd2, 13'h0040), 64'h1004, 1'b0);
        add_alu("x0_add", r_enc(7'h00, 3'd0, 5'd0, 5'd4, OP_REG), 64'h4);
        add_alu("x0_or",  r_enc(7'h00, 3'd6, 5'd0, 5'd0, OP_REG), 64'h0);
        add_alu("load_addr", i_enc(3'd3, 5'd4, 12'h100, LOAD), 64'h104);
        add_alu("store", s_enc(3'd3, 5'd1, 5'd3, 12'hff8), 64'h8);
        expect_rs2(64'h7fff_ffff);
    endtask

    task automatic preload_regs();
        for (int k = 0; k <= 6; k++) begin
            @(posedge clk);
            wb_en_i   <= 1'b1;
            wb_addr_i <= reg_addr_t'(k);
            wb_data_i <= preload_value(k);
        end
        @(posedge clk);
        wb_en_i <= 1'b0;
    endtask

    task automatic wait_valid_out(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (valid_o !== 1'b1) begin
            cycles++;
            if (cycles >= WAIT_MAX) begin
                fail_run($sformatf("valid_o never came for test %s", name));
            end
            @(negedge clk);
        end
    endtask

    task automatic run_case(input int i);
        @(posedge clk);
        valid_i <= 1'b1;
        pc_i    <= pc_q[i];
        instr_i <= instr_q[i];
        @(posedge clk);
        valid_i <= 1'b0;
        wait_valid_out(name_q[i]);
        if (chk_res_q[i]) begin
            check_value(name_q[i], "result", res_q[i], result_o);
        end
        check_value(name_q[i], "pc_next", nxt_q[i], pc_next_o);
        check_value(name_q[i], "is_jump", xlen_t'(jmp_q[i]), xlen_t'(is_jump_o));
        if (chk_rs2_q[i]) begin
            check_value(name_q[i], "rs2", rs2_q[i], rs2_o);
        end
    endtask

    initial begin
        reset_i   = 1'b1;
        valid_i   = 1'b0;
        pc_i      = '0;
        instr_i   = '0;
        wb_en_i   = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        build_table();
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("reset", "valid_o", '0, xlen_t'(valid_o));
        check_value("reset", "is_jump", '0, xlen_t'(is_jump_o));
        preload_regs();
        for (int i = 0; i < name_q.size(); i++) begin
            run_case(i);
        end
        $display("All tests passed");
        $finish;
    end

endmodule
